//--- hw/decodePkg.sv
//********************************************************************
// Shared field positions, widths and encodings for the decode stage.
// Modules refer to these by scoped names such as decodePkg::aluADD.
//********************************************************************

package decodePkg;

	// Instruction word layout, bit 35 is the leftmost PDP-10 bit 0
	localparam int wordWidth = 36;
	localparam int opWidth = 9;
	localparam int devWidth = 7;
	localparam int ioOpWidth = 3;
	localparam int ioDevWidth = 18;
	localparam int lowOpWidth = 6; // Opcode bits seen by the skip and test decoders

	localparam int opMsb = wordWidth - 1;
	localparam int opLsb = wordWidth - opWidth;
	localparam int devMsb = wordWidth - 4; // Below the 7xx marker
	localparam int devLsb = devMsb - devWidth + 1;
	localparam int ioOpMsb = devLsb - 1;
	localparam int ioOpLsb = ioOpMsb - ioOpWidth + 1;

	// Main branch in the execute FSM
	typedef enum logic [2:0] {
		dCommon = 3'd0,
		dMUUO = 3'd1,
		dUnassigned = 3'd2,
		dTEST = 3'd3,
		dIOread = 3'd4,
		dIOwrite = 3'd5
	} dispatch_e;

	// First sixteen follow the boolean opcode order
	typedef enum logic [4:0] {
		aluSETZ = 5'd0, aluAND = 5'd1, aluANDCA = 5'd2, aluSETM = 5'd3,
		aluANDCM = 5'd4, aluSETA = 5'd5, aluXOR = 5'd6, aluIOR = 5'd7,
		aluANDCB = 5'd8, aluEQV = 5'd9, aluSETCA = 5'd10, aluORCA = 5'd11,
		aluSETCM = 5'd12, aluORCM = 5'd13, aluORCB = 5'd14, aluSETO = 5'd15,
		aluADD = 5'd16,
		aluSUB = 5'd17,
		aluNEGATE = 5'd18,
		aluMAGNITUDE = 5'd19
	} aluOp_e;

	// Same order as the low three opcode bits of the skip group
	typedef enum logic [2:0] {
		skipNever = 3'd0,
		skipL = 3'd1,
		skipE = 3'd2,
		skipLE = 3'd3,
		skipA = 3'd4,
		skipGE = 3'd5,
		skipN = 3'd6,
		skipG = 3'd7
	} skipCond_e;

	// I/O function field
	typedef enum logic [2:0] {
		BLKI = 3'd0,
		DATAI = 3'd1,
		BLKO = 3'd2,
		DATAO = 3'd3,
		CONO = 3'd4,
		CONI = 3'd5,
		CONSZ = 3'd6,
		CONSO = 3'd7
	} ioOp_e;

endpackage

//--- hw/dataOpDecode.sv
//********************************************************************
// Decoder for the full-word moves, ADD/SUB and the boolean group.
// Purely combinational, driven from the registered opcode.
//********************************************************************

`timescale 1ns/1ps

module dataOpDecode (
	input logic [decodePkg::opWidth-1:0] op,
	output decodePkg::aluOp_e aluOp,
	output logic readE,
	output logic readAC,
	output logic mSwap,
	output logic writeE,
	output logic writeAC,
	output logic writeSelf
);

	always_comb begin
		aluOp = decodePkg::aluSETA;
		readE = 1'b0;
		readAC = 1'b0;
		mSwap = 1'b0;
		writeE = 1'b0;
		writeAC = 1'b0;
		writeSelf = 1'b0;

		if (op[8] || op[5]) begin
			// Booleans (4xx) and ADD/SUB (27x) share the four modes
			if (op[8])
				aluOp = decodePkg::aluOp_e'({1'b0, op[5:2]});
			else
				aluOp = op[2] ? decodePkg::aluSUB : decodePkg::aluADD;

			case (op[1:0])
				2'd0: {readE, writeAC} = 2'b11; // AC <- AC op C(E)
				2'd1: writeAC = 1'b1; // Immediate, AC <- AC op 0,,E
				2'd2: {readE, writeE} = 2'b11; // C(E) <- AC op C(E)
				default: {readE, writeE, writeAC} = 3'b111; // Both
			endcase
		end else begin
			// MOVE, MOVS, MOVN, MOVM
			case (op[3:2])
				2'd0: aluOp = decodePkg::aluSETM;
				2'd1: begin
					aluOp = decodePkg::aluSETM;
					mSwap = 1'b1;
				end
				2'd2: aluOp = decodePkg::aluNEGATE;
				default: aluOp = decodePkg::aluMAGNITUDE;
			endcase

			case (op[1:0])
				2'd0: {readE, writeAC} = 2'b11;
				2'd1: writeAC = 1'b1;
				2'd2: {readAC, writeE} = 2'b11; // Source is AC, result to memory
				default: {readE, writeE, writeSelf} = 3'b111; // Self, AC only if nonzero
			endcase
		end
	end

endmodule

//--- hw/skipJumpDecode.sv
//********************************************************************
// Decoder for opcodes 300-377: compares, jumps, skips and the
// add-one / subtract-one families. Condition comes from bits 2:0.
//********************************************************************

`timescale 1ns/1ps

module skipJumpDecode (
	input logic [decodePkg::lowOpWidth-1:0] op,
	output decodePkg::aluOp_e aluOp,
	output logic readE,
	output logic readAC,
	output logic readOne,
	output logic readMinusOne,
	output logic writeE,
	output logic writeAC,
	output logic writeSelf,
	output logic setFlags,
	output decodePkg::skipCond_e cond,
	output logic comp0,
	output logic jump
);

	typedef enum logic [2:0] {
		famCAI, famCAM, famJUMP, famSKIP, famAOJ, famAOS, famSOJ, famSOS
	} family_e;

	family_e family;

	assign family = family_e'(op[5:3]);
	assign cond = decodePkg::skipCond_e'(op[2:0]);

	always_comb begin
		aluOp = decodePkg::aluSETA;
		{readE, readAC, readOne, readMinusOne} = 4'b0000;
		{writeE, writeAC, writeSelf} = 3'b000;
		{setFlags, comp0, jump} = 3'b000;

		case (family)
			famCAI: aluOp = decodePkg::aluSUB; // AC against 0,,E
			famCAM: begin
				aluOp = decodePkg::aluSUB;
				readE = 1'b1;
			end
			famJUMP: begin
				aluOp = decodePkg::aluSETM;
				{readAC, comp0, jump} = 3'b111;
			end
			famSKIP: begin
				aluOp = decodePkg::aluSETM;
				{readE, writeSelf, comp0} = 3'b111;
			end
			famAOJ, famSOJ: begin
				// Adding -1 keeps the carry flags right for SOJ
				aluOp = decodePkg::aluADD;
				readOne = (family == famAOJ);
				readMinusOne = (family == famSOJ);
				{readAC, writeAC, setFlags, jump} = 4'b1111;
			end
			default: begin // AOS, SOS
				aluOp = decodePkg::aluADD;
				readOne = (family == famAOS);
				readMinusOne = (family == famSOS);
				{readE, writeE, writeSelf, setFlags, comp0} = 5'b11111;
			end
		endcase
	end

endmodule

//--- hw/testDecode.sv
//********************************************************************
// Decoder for the bit-test family, opcodes 600-677.
//********************************************************************

`timescale 1ns/1ps

module testDecode (
	input logic [decodePkg::lowOpWidth-1:0] op,
	output decodePkg::aluOp_e aluOp,
	output logic readE,
	output logic mSwap,
	output logic writeAC,
	output decodePkg::skipCond_e cond
);

	assign readE = op[3]; // D and S mask with C(E), R and L with E
	assign mSwap = op[0]; // L and S work on the swapped mask
	assign writeAC = (op[5:4] != 2'd0); // No write for N

	always_comb begin
		case (op[5:4])
			2'd0: aluOp = decodePkg::aluSETA; // N, AC unchanged
			2'd1: aluOp = decodePkg::aluANDCM; // Z
			2'd2: aluOp = decodePkg::aluXOR; // C
			default: aluOp = decodePkg::aluIOR; // O
		endcase

		case (op[2:1])
			2'd0: cond = decodePkg::skipNever;
			2'd1: cond = decodePkg::skipE;
			2'd2: cond = decodePkg::skipA;
			default: cond = decodePkg::skipN;
		endcase
	end

endmodule

//--- hw/ioDecode.sv
//********************************************************************
// Decoder for the I/O group 700-777. Applies the user-mode gate and
// forms the device address for the I/O bus.
//********************************************************************

`timescale 1ns/1ps

module ioDecode (
	input logic [decodePkg::devWidth-1:0] device,
	input decodePkg::ioOp_e ioOp,
	input logic user,
	input logic userIO,
	output decodePkg::dispatch_e dispatch,
	output decodePkg::aluOp_e aluOp,
	output logic readE,
	output logic writeE,
	output decodePkg::skipCond_e cond,
	output logic comp0,
	output logic [decodePkg::ioDevWidth-1:0] ioDev
);

	logic gateClosed;
	logic ioConditions; // Selects the conditions register of the device

	assign gateClosed = user && !userIO;

	// Device times four, plus one for the conditions register
	assign ioDev = {{(decodePkg::ioDevWidth - decodePkg::devWidth - 2){1'b0}},
		device, 1'b0, ioConditions};

	always_comb begin
		dispatch = decodePkg::dCommon;
		aluOp = decodePkg::aluSETA;
		{readE, writeE, comp0, ioConditions} = 4'b0000;
		cond = decodePkg::skipNever;

		if (gateClosed) begin
			dispatch = decodePkg::dMUUO; // Trap to the monitor
		end else begin
			case (ioOp)
				decodePkg::CONO: begin
					dispatch = decodePkg::dIOwrite;
					ioConditions = 1'b1;
				end
				decodePkg::CONI: begin
					dispatch = decodePkg::dIOread;
					{writeE, ioConditions} = 2'b11;
				end
				decodePkg::CONSZ: begin
					dispatch = decodePkg::dIOread;
					aluOp = decodePkg::aluAND;
					cond = decodePkg::skipE;
					{comp0, ioConditions} = 2'b11;
				end
				decodePkg::CONSO: begin
					dispatch = decodePkg::dIOread;
					aluOp = decodePkg::aluIOR;
					cond = decodePkg::skipN;
					{comp0, ioConditions} = 2'b11;
				end
				decodePkg::DATAO: begin
					dispatch = decodePkg::dIOwrite;
					aluOp = decodePkg::aluSETM;
					readE = 1'b1;
				end
				decodePkg::DATAI: begin
					dispatch = decodePkg::dIOread;
					writeE = 1'b1;
				end
				default: dispatch = decodePkg::dUnassigned; // Block transfers not done yet
			endcase
		end

		// A trapped user instruction must never touch memory
		if (gateClosed)
			assert (!readE && !writeE && !ioConditions)
			else $error("ioDecode: memory access on a trapped user I/O instruction");
	end

endmodule

//--- hw/decodeStage.sv
//********************************************************************
// Instruction decode pipeline stage. Registers the instruction word,
// runs the group decoders and registers the datapath controls, so
// decodeValid follows instValid by two clock edges.
//********************************************************************

`timescale 1ns/1ps

module decodeStage (
	input logic clk,
	input logic rstN,
	input logic [decodePkg::wordWidth-1:0] inst,
	input logic instValid,
	input logic user,
	input logic userIO,
	output logic decodeValid,
	output decodePkg::dispatch_e dispatch,
	output decodePkg::aluOp_e aluOp,
	output logic readE,
	output logic readAC,
	output logic readOne,
	output logic readMinusOne,
	output logic mSwap,
	output logic setFlags,
	output logic writeE,
	output logic writeAC,
	output logic writeSelf,
	output decodePkg::skipCond_e cond,
	output logic comp0,
	output logic jump,
	output logic [decodePkg::ioDevWidth-1:0] ioDev
);

	typedef enum logic [2:0] {grpMUUO, grpData, grpSkip, grpTest, grpIO, grpNone} group_e;

	logic [decodePkg::wordWidth-1:0] instQ;
	logic userQ, userIOQ;
	logic validQ;
	logic [decodePkg::opWidth-1:0] opQ;
	group_e grp;

	// Group decoder outputs
	decodePkg::aluOp_e dAluOp, sAluOp, tAluOp, iAluOp;
	logic dReadE, dReadAC, dMSwap, dWriteE, dWriteAC, dWriteSelf;
	logic sReadE, sReadAC, sReadOne, sReadMinusOne, sWriteE, sWriteAC, sWriteSelf;
	logic sSetFlags, sComp0, sJump;
	decodePkg::skipCond_e sCond, tCond, iCond;
	logic tReadE, tMSwap, tWriteAC;
	decodePkg::dispatch_e iDispatch;
	logic iReadE, iWriteE, iComp0;
	logic [decodePkg::ioDevWidth-1:0] iIoDev;

	// Merged controls ahead of the output register
	decodePkg::dispatch_e nDispatch;
	decodePkg::aluOp_e nAluOp;
	decodePkg::skipCond_e nCond;
	logic nReadE, nReadAC, nReadOne, nReadMinusOne, nMSwap, nSetFlags;
	logic nWriteE, nWriteAC, nWriteSelf, nComp0, nJump;
	logic [decodePkg::ioDevWidth-1:0] nIoDev;

	always_ff @(posedge clk) begin
		instQ <= inst; // Instruction word
		userQ <= user;
		userIOQ <= userIO;
		if (!rstN)
			validQ <= 1'b0;
		else
			validQ <= instValid;
	end

	assign opQ = instQ[decodePkg::opMsb:decodePkg::opLsb];

	dataOpDecode u_dataOp (
		.op(opQ), .aluOp(dAluOp), .readE(dReadE), .readAC(dReadAC), .mSwap(dMSwap),
		.writeE(dWriteE), .writeAC(dWriteAC), .writeSelf(dWriteSelf)
	);

	skipJumpDecode u_skipJump (
		.op(opQ[decodePkg::lowOpWidth-1:0]), .aluOp(sAluOp), .readE(sReadE),
		.readAC(sReadAC), .readOne(sReadOne), .readMinusOne(sReadMinusOne),
		.writeE(sWriteE), .writeAC(sWriteAC), .writeSelf(sWriteSelf),
		.setFlags(sSetFlags), .cond(sCond), .comp0(sComp0), .jump(sJump)
	);

	testDecode u_test (
		.op(opQ[decodePkg::lowOpWidth-1:0]), .aluOp(tAluOp), .readE(tReadE),
		.mSwap(tMSwap), .writeAC(tWriteAC), .cond(tCond)
	);

	ioDecode u_io (
		.device(instQ[decodePkg::devMsb:decodePkg::devLsb]),
		.ioOp(decodePkg::ioOp_e'(instQ[decodePkg::ioOpMsb:decodePkg::ioOpLsb])),
		.user(userQ), .userIO(userIOQ), .dispatch(iDispatch), .aluOp(iAluOp),
		.readE(iReadE), .writeE(iWriteE), .cond(iCond), .comp0(iComp0), .ioDev(iIoDev)
	);

	// Opcode ranges
	always_comb begin
		casez (opQ)
			9'b000_???_???: grp = grpMUUO; // 000-077
			9'b010_00?_???, 9'b010_111_???, 9'b100_???_???: grp = grpData;
			9'b011_???_???: grp = grpSkip;
			9'b110_???_???: grp = grpTest;
			9'b111_???_???: grp = grpIO;
			default: grp = grpNone; // Half-words, MUL/DIV, shifts and the rest
		endcase
	end

	always_comb begin
		nDispatch = decodePkg::dCommon;
		nAluOp = decodePkg::aluSETA;
		nCond = decodePkg::skipNever;
		{nReadE, nReadAC, nReadOne, nReadMinusOne, nMSwap, nSetFlags} = 6'b0;
		{nWriteE, nWriteAC, nWriteSelf, nComp0, nJump} = 5'b0;
		nIoDev = '0;

		case (grp)
			grpMUUO: nDispatch = decodePkg::dMUUO;
			grpData: begin
				{nAluOp, nReadE, nReadAC, nMSwap} = {dAluOp, dReadE, dReadAC, dMSwap};
				{nWriteE, nWriteAC, nWriteSelf} = {dWriteE, dWriteAC, dWriteSelf};
				nSetFlags = !opQ[8]; // Moves and ADD/SUB only
			end
			grpSkip: begin
				{nAluOp, nCond} = {sAluOp, sCond};
				{nReadE, nReadAC, nReadOne, nReadMinusOne} =
					{sReadE, sReadAC, sReadOne, sReadMinusOne};
				{nWriteE, nWriteAC, nWriteSelf} = {sWriteE, sWriteAC, sWriteSelf};
				{nSetFlags, nComp0, nJump} = {sSetFlags, sComp0, sJump};
			end
			grpTest: begin
				nDispatch = decodePkg::dTEST;
				{nAluOp, nCond, nReadE, nMSwap, nWriteAC} =
					{tAluOp, tCond, tReadE, tMSwap, tWriteAC};
			end
			grpIO: begin
				{nDispatch, nAluOp, nCond, nIoDev} = {iDispatch, iAluOp, iCond, iIoDev};
				{nReadE, nWriteE, nComp0} = {iReadE, iWriteE, iComp0};
			end
			default: nDispatch = decodePkg::dUnassigned;
		endcase
	end

	// Output register, holds between instructions
	always_ff @(posedge clk) begin
		if (!rstN) begin
			decodeValid <= 1'b0;
			dispatch <= decodePkg::dCommon;
			aluOp <= decodePkg::aluSETZ;
			cond <= decodePkg::skipNever;
			{readE, readAC, readOne, readMinusOne, mSwap, setFlags} <= 6'b0;
			{writeE, writeAC, writeSelf, comp0, jump} <= 5'b0;
			ioDev <= '0;
		end else begin
			decodeValid <= validQ;
			if (validQ) begin
				{dispatch, aluOp, cond, ioDev} <= {nDispatch, nAluOp, nCond, nIoDev};
				{readE, readAC, readOne, readMinusOne} <=
					{nReadE, nReadAC, nReadOne, nReadMinusOne};
				{mSwap, setFlags, comp0, jump} <= {nMSwap, nSetFlags, nComp0, nJump};
				{writeE, writeAC, writeSelf} <= {nWriteE, nWriteAC, nWriteSelf};
			end
		end
	end

	// The Amux can select only one constant
	assert property (@(posedge clk) decodeValid |-> !(readOne && readMinusOne))
		else $error("decodeStage: readOne and readMinusOne both set");

	// Both pipeline valids are flushed by reset
	assert property (@(posedge clk) !rstN |=> !decodeValid)
		else $error("decodeStage: decodeValid high right after reset");

endmodule

//--- testbench/decodeChecker.sv
//********************************************************************
// Watches the decode stage outputs, checks the two-cycle latency and
// compares each decode with the expected values in the stimulus file.
//********************************************************************

`timescale 1ns/1ps

module decodeChecker (
	input logic clk,
	input logic rstN,
	input logic instValid,
	input logic decodeValid,
	input decodePkg::dispatch_e dispatch,
	input decodePkg::aluOp_e aluOp,
	input logic readE, readAC, readOne, readMinusOne, mSwap, setFlags,
	input logic writeE, writeAC, writeSelf, comp0, jump,
	input decodePkg::skipCond_e cond,
	input logic [decodePkg::ioDevWidth-1:0] ioDev,
	output logic done,
	output int valueErrors,
	output int timingErrors,
	output int otherErrors
);

	int cycle;
	int issued[$]; // Cycle numbers of instructions in flight

	// Outputs are looked at on the falling edge, away from the registers
	task automatic stepCycle;
		@(negedge clk);
		cycle++;
		if (instValid && rstN)
			issued.push_back(cycle);
	endtask

	task automatic compareField(input logic [8*12-1:0] name, input string field,
		input int expected, input int actual);
		if (expected != actual) begin
			valueErrors++;
			$display("FAIL %0s %0s expected %0h actual %0h", name, field, expected, actual);
		end
	endtask

	task automatic checkLatency(input logic [8*12-1:0] name);
		int start;
		if (issued.size() == 0) begin
			timingErrors++;
			$display("decodeValid high at cycle %0d with no instruction in flight", cycle);
		end else begin
			start = issued.pop_front();
			if (cycle - start != 2) begin
				timingErrors++;
				$display("FAIL %0s latency expected 2 actual %0d", name, cycle - start);
			end
		end
	endtask

	initial begin
		int fd;
		int count;
		int waitCount;
		int u, uio, gap;
		int expDispatch, expAlu, expCond;
		string line;
		logic [8*12-1:0] name;
		logic [decodePkg::wordWidth-1:0] word;
		logic [decodePkg::ioDevWidth-1:0] expDev;
		logic [11:0] expFlags;
		logic [11:0] actFlags;
		logic running;

		done = 1'b0;
		valueErrors = 0;
		timingErrors = 0;
		otherErrors = 0;
		cycle = 0;
		fd = $fopen("testbench/decode_stimulus.txt", "r");
		if (fd == 0) begin
			otherErrors++;
			$display("Could not open the stimulus file");
		end

		// Nothing may come out while reset is held
		waitCount = 0;
		stepCycle;
		while (!rstN && waitCount < 100) begin
			if (decodeValid) begin
				timingErrors++;
				$display("decodeValid high during reset at cycle %0d", cycle);
			end
			stepCycle;
			waitCount++;
		end
		if (!rstN) begin
			otherErrors++;
			$display("Reset was never released");
		end

		running = (fd != 0) && rstN;
		while (running && !$feof(fd)) begin
			count = $fgets(line, fd);
			if (count != 0 && $sscanf(line, "%s %o %d %d %d %d %d %d %h %h", name, word, u,
				uio, gap, expDispatch, expAlu, expCond, expDev, expFlags) == 10) begin
				waitCount = 0;
				stepCycle;
				while (!decodeValid && waitCount < 64) begin
					stepCycle;
					waitCount++;
				end
				if (!decodeValid) begin
					otherErrors++;
					$display("Timed out waiting for decodeValid on %0s", name);
					running = 1'b0;
				end else begin
					checkLatency(name);
					actFlags = {1'b0, readE, readAC, readOne, readMinusOne, mSwap, setFlags,
						writeE, writeAC, writeSelf, comp0, jump};
					compareField(name, "dispatch", expDispatch, int'(dispatch));
					compareField(name, "aluOp", expAlu, int'(aluOp));
					compareField(name, "cond", expCond, int'(cond));
					compareField(name, "ioDev", int'(expDev), int'(ioDev));
					compareField(name, "flags", int'(expFlags), int'(actFlags));
				end
			end
		end

		// A late or doubled pulse would show up here
		repeat (8) begin
			stepCycle;
			if (decodeValid) begin
				timingErrors++;
				$display("Extra decodeValid pulse at cycle %0d", cycle);
			end
		end
		done = 1'b1;
	end

endmodule

//--- testbench/tbTop.sv
//********************************************************************
// Testbench top for the decode stage. Makes clock and reset, drives
// instructions from the stimulus file and reports the final result.
//********************************************************************

`timescale 1ns/1ps

module tbTop;

	logic clk;
	logic rstN;
	logic [decodePkg::wordWidth-1:0] inst;
	logic instValid;
	logic user;
	logic userIO;

	logic decodeValid;
	decodePkg::dispatch_e dispatch;
	decodePkg::aluOp_e aluOp;
	logic readE, readAC, readOne, readMinusOne, mSwap, setFlags;
	logic writeE, writeAC, writeSelf, comp0, jump;
	decodePkg::skipCond_e cond;
	logic [decodePkg::ioDevWidth-1:0] ioDev;

	logic done;
	int valueErrors, timingErrors, otherErrors;
	int seed;

	decodeStage i_dut (.*);

	decodeChecker u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		int fd;
		int count;
		int gap;
		int u;
		int uio;
		int waitCount;
		string line;
		logic [8*12-1:0] name;
		logic [decodePkg::wordWidth-1:0] word;
		logic [31:0] rnd;

		seed = 32'h377ed5fe;
		rstN = 1'b0;
		inst = '0;
		instValid = 1'b1; // Pending during reset, must be flushed
		user = 1'b0;
		userIO = 1'b0;
		fd = $fopen("testbench/decode_stimulus.txt", "r");

		repeat (16) @(posedge clk);
		rstN <= 1'b1;
		instValid <= 1'b0;

		while (fd != 0 && !$feof(fd)) begin
			count = $fgets(line, fd);
			if (count != 0 && $sscanf(line, "%s %o %d %d %d", name, word, u, uio, gap) == 5) begin
				repeat (gap) begin
					@(posedge clk);
					instValid <= 1'b0;
				end
				rnd = $random(seed);
				if (word[35:33] == 3'o7)
					word[22:0] = rnd[22:0]; // Below device and function
				else
					word[26:0] = rnd[26:0]; // Everything below the opcode
				@(posedge clk);
				inst <= word;
				user <= u[0];
				userIO <= uio[0];
				instValid <= 1'b1;
			end
		end
		@(posedge clk);
		instValid <= 1'b0;

		waitCount = 0;
		while (!done && waitCount < 500) begin
			@(posedge clk);
			waitCount++;
		end

		$display("Errors: value %0d, timing %0d, other %0d",
			valueErrors, timingErrors, otherErrors);
		if (done && valueErrors + timingErrors + otherErrors == 0) begin
			$display("All checks passed");
		end else begin
			if (!done)
				$display("Timed out waiting for the checker to finish");
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- testbench/decode_stimulus.txt
# name inst(octal) user userIO gap | expected: dispatch aluOp cond ioDev(hex) flags(hex)
# flags bits 10..0: readE readAC readOne readMinusOne mSwap setFlags writeE writeAC writeSelf comp0 jump
move 200000000000 0 0 0 0 3 0 0 428
movsi 205000000000 0 0 0 0 3 0 0 068
movnm 212000000000 0 0 1 0 18 0 0 230
movms 217000000000 0 0 0 0 19 0 0 434
add 270000000000 0 0 0 0 16 0 0 428
subi 275000000000 0 0 0 0 17 0 0 028
addm 272000000000 0 0 2 0 16 0 0 430
subb 277000000000 0 0 0 0 17 0 0 438
setz 400000000000 0 0 0 0 0 0 0 408
andi 405000000000 0 0 0 0 1 0 0 008
xorm 432000000000 0 0 0 0 6 0 0 410
iorb 437000000000 0 0 0 0 7 0 0 418
eqv 444000000000 0 0 0 0 9 0 0 408
orcmi 465000000000 0 0 0 0 13 0 0 008
setob 477000000000 0 0 0 0 15 0 0 418
cail 301000000000 0 0 0 0 17 1 0 000
camge 315000000000 0 0 0 0 17 5 0 400
jumpe 322000000000 0 0 0 0 3 2 0 203
skipa 334000000000 0 0 1 0 3 4 0 406
aojle 343000000000 0 0 0 0 16 3 0 329
aos 350000000000 0 0 0 0 16 0 0 536
sojn 366000000000 0 0 0 0 16 6 0 2a9
sosg 377000000000 0 0 0 0 16 7 0 4b6
trn 600000000000 0 0 0 3 5 0 0 000
tlne 603000000000 0 0 0 3 5 2 0 040
tdza 634000000000 0 0 0 3 4 4 0 408
tscn 657000000000 0 0 0 3 6 6 0 448
tro 660000000000 0 0 0 3 7 0 0 008
tloe 663000000000 0 0 0 3 7 2 0 048
tdzn 636000000000 0 0 0 3 4 6 0 408
tsna 615000000000 0 0 0 3 5 4 0 440
cono 706200000000 0 0 0 5 5 0 31 000
coni 706240000000 0 0 0 4 5 0 31 010
consz 706300000000 0 0 0 4 1 2 31 002
conso 706340000000 0 0 0 4 7 6 31 002
datao 706140000000 0 0 0 5 3 0 30 400
datai 706040000000 0 0 0 4 5 0 30 010
conoDev177 777600000000 0 0 0 5 5 0 1fd 000
coniUser 706240000000 1 0 1 1 5 0 30 000
conoUserIO 706200000000 1 1 0 5 5 0 31 000
muuo040 040000000000 0 0 3 1 5 0 0 000
imul 220000000000 0 0 0 2 5 0 0 000
hll 500000000000 0 0 0 2 5 0 0 000
blki 706000000000 0 0 0 2 5 0 30 000
exch 250000000000 0 0 0 2 5 0 0 000

//--- tb.f
hw/decodePkg.sv
hw/dataOpDecode.sv
hw/skipJumpDecode.sv
hw/testDecode.sv
hw/ioDecode.sv
hw/decodeStage.sv
testbench/decodeChecker.sv
testbench/tbTop.sv

//--- run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tbTop -o simTb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/simTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1
